//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP      = dmaTb
FILELIST = dmaController.f
BUILDDIR = obj_dir
RUNFLAGS = +verilator+error+limit+1000
PASSMSG  = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) $(RUNFLAGS) | tee /dev/stderr | grep -F '$(PASSMSG)' > /dev/null

clean:
	rm -rf $(BUILDDIR)

//--- dmaController.f
verilog/dmaPkg.sv
verilog/dmaTimingControl.sv
verilog/dmaPriority.sv
verilog/dmaRegisters.sv
verilog/dmaChannelCounter.sv
verilog/dmaController.sv
verif/dmaClockGen.sv
verif/dmaController_asserts.sv
verif/dmaTb.sv

//--- verif/dmaClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module dmaClockGen (
  output logic busIf,
  output logic reset
);

  initial begin
    busIf = 1'b0;
    forever #5 busIf = ~busIf;
  end

  // reset leaves just after the fifth rising edge
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge busIf);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/dmaController_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dmaController_asserts
  import dmaPkg::*;
(
  input wire logic       busIf,
  input wire logic       reset,
  input dmaState_t       state,
  input wire logic       hlda,
  input wire logic [3:0] dreq,
  input wire logic       rotating,
  input wire logic       hrq,
  input wire logic       aen,
  input wire logic       adstb,
  input wire logic [3:0] dack,
  input wire logic       memrN,
  input wire logic       memwN,
  input wire logic       ioReadN,
  input wire logic       ioWriteN,
  input wire logic       eopN
);

  int assertFails = 0;

  // legal successors of every timing state
  siNext: assert property (@(posedge busIf) disable iff (reset)
    state == stateSI |=> state == stateSI || state == stateSO)
    else begin assertFails++; $error("SI left for a state other than SO"); end
  soHold: assert property (@(posedge busIf) disable iff (reset)
    state == stateSO && !hlda |=> state == stateSO)
    else begin assertFails++; $error("SO did not hold while hlda was low"); end
  soGo: assert property (@(posedge busIf) disable iff (reset)
    state == stateSO && hlda |=> state == stateS1)
    else begin assertFails++; $error("SO did not move to S1 on hlda"); end
  s1Next: assert property (@(posedge busIf) disable iff (reset)
    state == stateS1 |=> state == stateS2)
    else begin assertFails++; $error("S1 was not followed by S2"); end
  s2Next: assert property (@(posedge busIf) disable iff (reset)
    state == stateS2 |=> state == stateS4)
    else begin assertFails++; $error("S2 was not followed by S4"); end
  s4Next: assert property (@(posedge busIf) disable iff (reset)
    state == stateS4 |=> state == stateSI)
    else begin assertFails++; $error("S4 was not followed by SI"); end

  resetValues: assert property (@(posedge busIf)
    reset |=> state == stateSI && !hrq && !aen && !adstb && dack == 4'h0
              && memrN && memwN && ioReadN && ioWriteN && eopN)
    else begin assertFails++; $error("outputs not idle after reset"); end

  dackOneHot: assert property (@(posedge busIf) disable iff (reset)
    state == stateS2 || state == stateS4 |-> $onehot(dack))
    else begin assertFails++; $error("dack not one-hot in S2 or S4"); end
  dackWindow: assert property (@(posedge busIf) disable iff (reset)
    dack != 4'h0 |-> state == stateS2 || state == stateS4)
    else begin assertFails++; $error("dack active outside S2 and S4"); end

  // grant is latched on the SO to S1 edge, dack shows it two cycles later
  fixedPriority: assert property (@(posedge busIf) disable iff (reset)
    state == stateS2 && $past(state == stateSO && hlda && dreq == 4'b0011 && !rotating, 2)
    |-> dack == 4'b0001)
    else begin assertFails++; $error("channel 0 lost against channel 1 in fixed mode"); end

  eopOnlyS4: assert property (@(posedge busIf) disable iff (reset)
    !eopN |-> state == stateS4)
    else begin assertFails++; $error("eopN low outside S4"); end

endmodule

bind dmaController dmaController_asserts dmaController_asserts_i (
  .busIf, .reset, .state, .hlda, .dreq, .rotating, .hrq, .aen, .adstb, .dack,
  .memrN, .memwN, .ioReadN, .ioWriteN, .eopN
);

`default_nettype wire

//--- verif/dmaTb.sv
`timescale 1ns/1ps
`default_nettype none

module dmaTb
  import dmaPkg::*;
();

  logic        busIf;
  logic        reset;
  logic        csN;
  logic        cpuReadN;
  logic        cpuWriteN;
  logic [3:0]  cpuAddr;
  logic [7:0]  cpuDataIn;
  logic [7:0]  cpuDataOut;
  logic [3:0]  dreq;
  logic        hlda;
  logic        hrq;
  logic [3:0]  dack;
  logic        aen;
  logic        adstb;
  logic [15:0] addrOut;
  logic        memrN;
  logic        memwN;
  logic        ioReadN;
  logic        ioWriteN;
  logic        eopN;

  // reference model of the channel registers
  logic [15:0] modelAddr  [numChannels];
  logic [15:0] modelCount [numChannels];
  logic [15:0] baseAddr   [numChannels];
  logic [15:0] baseCount  [numChannels];
  xferType_t   modeType   [numChannels];
  logic        modeAuto   [numChannels];
  logic        modeDec    [numChannels];
  logic [3:0]  modelStatus;
  logic [31:0] lfsr;
  int          checks;
  int          errors;
  logic        timedOut;

  dmaClockGen dmaClockGen_i (.busIf, .reset);

  dmaController dmaController_i (
    .busIf, .reset, .csN, .cpuReadN, .cpuWriteN, .cpuAddr, .cpuDataIn, .cpuDataOut,
    .dreq, .hlda, .hrq, .dack, .aen, .adstb, .addrOut, .memrN, .memwN, .ioReadN,
    .ioWriteN, .eopN
  );

  task automatic finishRun();
    int failedAsserts;
    failedAsserts = dmaController_i.dmaController_asserts_i.assertFails;
    $display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, failedAsserts, timedOut);
    if (errors == 0 && failedAsserts == 0 && !timedOut) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic checkValue(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic logic conditionMet(input int which);
    case (which)
      0: return !reset;
      1: return hrq;
      default: return adstb;
    endcase
  endfunction

  task automatic waitFor(input int which, input string what);
    int cycles;
    cycles = 0;
    while (!conditionMet(which) && cycles < 50) begin
      @(negedge busIf);
      cycles++;
    end
    if (!conditionMet(which)) begin
      $display("timeout while waiting for %s", what);
      timedOut = 1'b1;
      finishRun();
    end
  endtask

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  task automatic randomRequest(output logic [3:0] req);
    for (int i = 0; i < 4; i++) begin
      req[i] = lfsr[0];
      lfsr = lfsrNext(lfsr);
    end
  endtask

  function automatic logic [1:0] lowestSet(input logic [3:0] req);
    logic [1:0] lowest;
    lowest = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (req[i]) lowest = 2'(i);
    end
    return lowest;
  endfunction

  // {memrN, memwN, ioReadN, ioWriteN} for S2 or S4
  function automatic logic [3:0] strobeExpect(input xferType_t kind, input logic inS4);
    logic [3:0] s;
    s = 4'b1111;
    if (kind == xferWrite) begin
      s[1] = 1'b0;
      s[2] = !inS4;
    end else if (kind == xferRead) begin
      s[3] = 1'b0;
      s[0] = !inS4;
    end
    return s;
  endfunction

  task automatic writeByte(input logic [3:0] addr, input logic [7:0] data);
    @(posedge busIf);
    #1;
    csN = 1'b0;
    cpuWriteN = 1'b0;
    cpuAddr = addr;
    cpuDataIn = data;
    @(posedge busIf);
    #1;
    csN = 1'b1;
    cpuWriteN = 1'b1;
  endtask

  task automatic readByte(input logic [3:0] addr, output logic [7:0] data);
    @(posedge busIf);
    #1;
    csN = 1'b0;
    cpuReadN = 1'b0;
    cpuAddr = addr;
    @(negedge busIf);
    data = cpuDataOut;
    @(posedge busIf);
    #1;
    csN = 1'b1;
    cpuReadN = 1'b1;
  endtask

  task automatic writeWord(input logic [3:0] addr, input logic [15:0] value);
    writeByte(regClearFlipFlop, 8'h00);
    writeByte(addr, value[7:0]);
    writeByte(addr, value[15:8]);
  endtask

  task automatic checkWord(input logic [3:0] addr, input logic [15:0] exp, input string name);
    logic [7:0] lo;
    logic [7:0] hi;
    writeByte(regClearFlipFlop, 8'h00);
    readByte(addr, lo);
    readByte(addr, hi);
    checkValue(name, {hi, lo}, exp);
  endtask

  task automatic programChannel(input logic [1:0] ch, input logic [15:0] addr,
                                input logic [15:0] count);
    writeWord({1'b0, ch, 1'b0}, addr);
    writeWord({1'b0, ch, 1'b1}, count);
    baseAddr[ch] = addr;
    modelAddr[ch] = addr;
    baseCount[ch] = count;
    modelCount[ch] = count;
  endtask

  task automatic checkChannel(input logic [1:0] ch);
    checkWord({1'b0, ch, 1'b0}, modelAddr[ch], "cpuDataOut address");
    checkWord({1'b0, ch, 1'b1}, modelCount[ch], "cpuDataOut count");
  endtask

  task automatic writeMode(input logic [1:0] ch, input xferType_t kind, input logic auto,
                           input logic dec);
    logic [7:0] mode;
    mode = 8'h00;
    mode[modeChannelLsb +: 2] = ch;
    mode[modeTypeLsb +: 2] = kind;
    mode[modeAutoInitBit] = auto;
    mode[modeDecrementBit] = dec;
    writeByte(regMode, mode);
    modeType[ch] = kind;
    modeAuto[ch] = auto;
    modeDec[ch] = dec;
  endtask

  task automatic writeCommand(input logic rotate, input logic halt);
    logic [7:0] cmd;
    cmd = 8'h00;
    cmd[cmdRotatingBit] = rotate;
    cmd[cmdDisableBit] = halt;
    writeByte(regCommandStatus, cmd);
  endtask

  // status read also clears the terminal-count flags
  task automatic checkStatus();
    logic [7:0] status;
    readByte(regCommandStatus, status);
    checkValue("status", 16'(status), 16'({dreq, modelStatus}));
    modelStatus = 4'h0;
  endtask

  task automatic runTransfer(input logic [1:0] ch, input logic [3:0] req);
    logic tc;
    tc = (modelCount[ch] == 16'h0000);
    @(posedge busIf);
    #1;
    dreq = req;
    waitFor(1, "hrq");
    // hold the bus back a little so SO has to wait
    repeat (2) @(posedge busIf);
    #1;
    hlda = 1'b1;
    waitFor(2, "adstb");
    checkValue("addrOut", addrOut, modelAddr[ch]);
    @(posedge busIf);
    #1;
    dreq = req & ~(4'b0001 << ch);
    @(negedge busIf);
    checkValue("dack", 16'(dack), 16'(4'b0001 << ch));
    checkValue("strobes in S2", 16'({memrN, memwN, ioReadN, ioWriteN}),
               16'(strobeExpect(modeType[ch], 1'b0)));
    @(negedge busIf);
    checkValue("strobes in S4", 16'({memrN, memwN, ioReadN, ioWriteN}),
               16'(strobeExpect(modeType[ch], 1'b1)));
    checkValue("eopN", 16'(eopN), 16'(!tc));
    checkValue("aen", 16'(aen), 16'h0001);
    checkValue("addrOut in S4", addrOut, modelAddr[ch]);
    @(posedge busIf);
    #1;
    hlda = 1'b0;
    if (tc) modelStatus[ch] = 1'b1;
    if (tc && modeAuto[ch]) begin
      modelAddr[ch] = baseAddr[ch];
      modelCount[ch] = baseCount[ch];
    end else begin
      modelAddr[ch] = modeDec[ch] ? modelAddr[ch] - 16'd1 : modelAddr[ch] + 16'd1;
      modelCount[ch] = modelCount[ch] - 16'd1;
    end
  endtask

  initial begin
    logic [3:0] req;
    csN = 1'b1;
    cpuReadN = 1'b1;
    cpuWriteN = 1'b1;
    cpuAddr = 4'h0;
    cpuDataIn = 8'h00;
    dreq = 4'h0;
    hlda = 1'b0;
    lfsr = 32'ha490;
    checks = 0;
    errors = 0;
    timedOut = 1'b0;
    modelStatus = 4'h0;
    for (int i = 0; i < numChannels; i++) begin
      modelAddr[i] = 16'h0000;
      modelCount[i] = 16'h0000;
      baseAddr[i] = 16'h0000;
      baseCount[i] = 16'h0000;
      modeType[i] = xferVerify;
      modeAuto[i] = 1'b0;
      modeDec[i] = 1'b0;
    end
    waitFor(0, "reset release");

    // idle bus and cleared registers after reset
    checkValue("bus outputs", 16'({hrq, aen, adstb, dack, memrN, memwN, ioReadN, ioWriteN, eopN}),
               16'h001f);
    checkStatus();
    for (int i = 0; i < numChannels; i++) checkChannel(2'(i));

    // a stray low byte leaves the flip-flop pointing at the high byte
    writeByte(4'd0, 8'hee);
    programChannel(2'd0, 16'ha5c3, 16'h0010);
    programChannel(2'd1, 16'h2000, 16'h0010);
    programChannel(2'd2, 16'h3456, 16'h0020);
    for (int i = 0; i < numChannels; i++) checkChannel(2'(i));

    writeMode(2'd2, xferWrite, 1'b0, 1'b0);
    runTransfer(2'd2, 4'b0100);
    checkChannel(2'd2);
    writeMode(2'd2, xferRead, 1'b0, 1'b0);
    runTransfer(2'd2, 4'b0100);
    writeMode(2'd2, xferVerify, 1'b0, 1'b1);
    runTransfer(2'd2, 4'b0100);
    checkChannel(2'd2);

    // a disabled controller ignores requests
    writeCommand(1'b0, 1'b1);
    @(posedge busIf);
    #1;
    dreq = 4'b0001;
    repeat (4) begin
      @(negedge busIf);
      checkValue("hrq", 16'(hrq), 16'h0000);
    end
    // upper status nibble follows the request lines
    checkStatus();
    @(posedge busIf);
    #1;
    dreq = 4'b0000;
    writeCommand(1'b0, 1'b0);

    runTransfer(2'd0, 4'b0011);
    runTransfer(2'd1, 4'b0010);
    for (int i = 0; i < 12; i++) begin
      randomRequest(req);
      if (req == 4'h0) req = 4'b1000;
      runTransfer(lowestSet(req), req);
    end
    @(posedge busIf);
    #1;
    dreq = 4'h0;

    writeCommand(1'b1, 1'b0);
    runTransfer(2'd0, 4'b0001);
    runTransfer(2'd1, 4'b0011);
    runTransfer(2'd0, 4'b0001);
    writeCommand(1'b0, 1'b0);

    // count of 1 gives two transfers, the second one ends the block
    checkStatus();
    writeMode(2'd3, xferVerify, 1'b1, 1'b0);
    programChannel(2'd3, 16'h4000, 16'h0001);
    runTransfer(2'd3, 4'b1000);
    runTransfer(2'd3, 4'b1000);
    checkStatus();
    checkStatus();
    checkChannel(2'd3);

    finishRun();
  end

endmodule

`default_nettype wire

//--- verilog/dmaChannelCounter.sv
`timescale 1ns/1ps
`default_nettype none

module dmaChannelCounter
  import dmaPkg::*;
(
  input  wire logic       busIf,
  input  wire logic       reset,
  input  wire logic       masterClear,
  input  wire logic       cntLoadAddr,
  input  wire logic       cntLoadCount,
  input  wire logic [1:0] loadChannel,
  input  wire logic       loadHigh,
  input  wire logic [7:0] loadByte,
  input  wire logic       stepPulse,
  input  wire logic [1:0] activeChannel,
  input  wire logic       decrement,
  input  wire logic       autoInit,
  input  wire logic [1:0] cpuChannel,
  output logic [15:0]     currentAddr,
  output logic            terminalCount,
  output logic [3:0]      tcPulse,
  output logic [15:0]     readAddr,
  output logic [15:0]     readCount
);

  logic [15:0] baseAddr  [numChannels];
  logic [15:0] curAddr   [numChannels];
  logic [15:0] baseCount [numChannels];
  logic [15:0] curCount  [numChannels];

  always_ff @(posedge busIf) begin
    if (reset || masterClear) begin
      for (int i = 0; i < numChannels; i++) begin
        baseAddr[i]  <= 16'h0000;
        curAddr[i]   <= 16'h0000;
        baseCount[i] <= 16'h0000;
        curCount[i]  <= 16'h0000;
      end
    end else if (cntLoadAddr) begin
      // cpu writes land in base and current together
      if (loadHigh) begin
        baseAddr[loadChannel][15:8] <= loadByte;
        curAddr[loadChannel][15:8]  <= loadByte;
      end else begin
        baseAddr[loadChannel][7:0] <= loadByte;
        curAddr[loadChannel][7:0]  <= loadByte;
      end
    end else if (cntLoadCount) begin
      if (loadHigh) begin
        baseCount[loadChannel][15:8] <= loadByte;
        curCount[loadChannel][15:8]  <= loadByte;
      end else begin
        baseCount[loadChannel][7:0] <= loadByte;
        curCount[loadChannel][7:0]  <= loadByte;
      end
    end else if (stepPulse) begin
      if (terminalCount && autoInit) begin
        curAddr[activeChannel]  <= baseAddr[activeChannel];
        curCount[activeChannel] <= baseCount[activeChannel];
      end else begin
        // without autoinit the count simply wraps past zero
        curAddr[activeChannel]  <= decrement ? curAddr[activeChannel] - 16'd1
                                             : curAddr[activeChannel] + 16'd1;
        curCount[activeChannel] <= curCount[activeChannel] - 16'd1;
      end
    end
  end

  assign currentAddr   = curAddr[activeChannel];
  assign terminalCount = (curCount[activeChannel] == 16'h0000);
  assign tcPulse       = (stepPulse && terminalCount) ? (4'b0001 << activeChannel) : 4'b0000;

  assign readAddr  = curAddr[cpuChannel];
  assign readCount = curCount[cpuChannel];

endmodule

`default_nettype wire

//--- verilog/dmaController.sv
`timescale 1ns/1ps
`default_nettype none

module dmaController
  import dmaPkg::*;
(
  input  wire logic        busIf,
  input  wire logic        reset,
  input  wire logic        csN,
  input  wire logic        cpuReadN,
  input  wire logic        cpuWriteN,
  input  wire logic [3:0]  cpuAddr,
  input  wire logic [7:0]  cpuDataIn,
  output logic [7:0]       cpuDataOut,
  input  wire logic [3:0]  dreq,
  input  wire logic        hlda,
  output logic             hrq,
  output logic [3:0]       dack,
  output logic             aen,
  output logic             adstb,
  output logic [15:0]      addrOut,
  output logic             memrN,
  output logic             memwN,
  output logic             ioReadN,
  output logic             ioWriteN,
  output logic             eopN
);

  dmaState_t   state;
  xferType_t   xferType;
  logic        anyRequest;
  logic [1:0]  grantChannel;
  logic [1:0]  activeChannel;
  logic        stepPulse;
  logic        serviceDone;
  logic        masterClear;
  logic        controllerDisable;
  logic        rotating;
  logic        autoInit;
  logic        decrement;
  logic        cntLoadAddr;
  logic        cntLoadCount;
  logic [1:0]  loadChannel;
  logic        loadHigh;
  logic [7:0]  loadByte;
  logic [1:0]  cpuChannel;
  logic [15:0] currentAddr;
  logic        terminalCount;
  logic [3:0]  tcPulse;
  logic [15:0] readAddr;
  logic [15:0] readCount;

  dmaTimingControl dmaTimingControl_i (
    .busIf, .reset, .anyRequest, .grantChannel, .hlda, .controllerDisable,
    .xferType, .terminalCount, .state, .activeChannel, .hrq, .aen, .adstb,
    .dack, .memrN, .memwN, .ioReadN, .ioWriteN, .eopN, .stepPulse, .serviceDone
  );

  dmaPriority dmaPriority_i (
    .busIf, .reset, .masterClear, .dreq, .rotating, .serviceDone, .activeChannel,
    .anyRequest, .grantChannel
  );

  dmaRegisters dmaRegisters_i (
    .busIf, .reset, .csN, .cpuReadN, .cpuWriteN, .cpuAddr, .cpuDataIn, .aen, .dreq,
    .tcPulse, .activeChannel, .readAddr, .readCount, .cpuDataOut, .masterClear,
    .controllerDisable, .rotating, .xferType, .autoInit, .decrement, .cntLoadAddr,
    .cntLoadCount, .loadChannel, .loadHigh, .loadByte, .cpuChannel
  );

  dmaChannelCounter dmaChannelCounter_i (
    .busIf, .reset, .masterClear, .cntLoadAddr, .cntLoadCount, .loadChannel,
    .loadHigh, .loadByte, .stepPulse, .activeChannel, .decrement, .autoInit,
    .cpuChannel, .currentAddr, .terminalCount, .tcPulse, .readAddr, .readCount
  );

  // address bus is only driven while the controller owns it
  assign addrOut = aen ? currentAddr : 16'h0000;

endmodule

`default_nettype wire

//--- verilog/dmaPkg.sv
`default_nettype none

package dmaPkg;

  localparam int numChannels = 4;

  // timing states of one single transfer
  typedef enum logic [2:0] {
    stateSI = 3'd0,
    stateSO = 3'd1,
    stateS1 = 3'd2,
    stateS2 = 3'd3,
    stateS4 = 3'd4
  } dmaState_t;

  // mode bits 3:2
  typedef enum logic [1:0] {
    xferVerify = 2'd0,
    xferWrite  = 2'd1,
    xferRead   = 2'd2
  } xferType_t;

  // cpu register map, 0 to 7 are the channel address and count registers
  localparam logic [3:0] regCommandStatus = 4'd8;
  localparam logic [3:0] regMode          = 4'd11;
  localparam logic [3:0] regClearFlipFlop = 4'd12;
  localparam logic [3:0] regMasterClear   = 4'd13;

  localparam int cmdDisableBit  = 2;
  localparam int cmdRotatingBit = 4;

  localparam int modeChannelLsb   = 0;
  localparam int modeTypeLsb      = 2;
  localparam int modeAutoInitBit  = 4;
  localparam int modeDecrementBit = 5;

endpackage

`default_nettype wire

//--- verilog/dmaPriority.sv
`timescale 1ns/1ps
`default_nettype none

module dmaPriority
  import dmaPkg::*;
(
  input  wire logic       busIf,
  input  wire logic       reset,
  input  wire logic       masterClear,
  input  wire logic [3:0] dreq,
  input  wire logic       rotating,
  input  wire logic       serviceDone,
  input  wire logic [1:0] activeChannel,
  output logic            anyRequest,
  output logic [1:0]      grantChannel
);

  // last channel served, lowest priority in rotating mode
  logic [1:0] pointer;
  logic [1:0] startChannel;
  logic [1:0] candidate;
  logic       found;

  always_ff @(posedge busIf) begin
    if (reset || masterClear) begin
      pointer <= 2'd0;
    end else if (serviceDone) begin
      pointer <= activeChannel;
    end
  end

  always_comb begin
    anyRequest   = |dreq;
    grantChannel = 2'd0;
    found        = 1'b0;
    startChannel = rotating ? pointer + 2'd1 : 2'd0;
    candidate    = startChannel;
    // search wraps around the channels from the start point
    for (int i = 0; i < numChannels; i++) begin
      candidate = startChannel + 2'(i);
      if (!found && dreq[candidate]) begin
        grantChannel = candidate;
        found        = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmaRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module dmaRegisters
  import dmaPkg::*;
(
  input  wire logic        busIf,
  input  wire logic        reset,
  input  wire logic        csN,
  input  wire logic        cpuReadN,
  input  wire logic        cpuWriteN,
  input  wire logic [3:0]  cpuAddr,
  input  wire logic [7:0]  cpuDataIn,
  input  wire logic        aen,
  input  wire logic [3:0]  dreq,
  input  wire logic [3:0]  tcPulse,
  input  wire logic [1:0]  activeChannel,
  input  wire logic [15:0] readAddr,
  input  wire logic [15:0] readCount,
  output logic [7:0]       cpuDataOut,
  output logic             masterClear,
  output logic             controllerDisable,
  output logic             rotating,
  output xferType_t        xferType,
  output logic             autoInit,
  output logic             decrement,
  output logic             cntLoadAddr,
  output logic             cntLoadCount,
  output logic [1:0]       loadChannel,
  output logic             loadHigh,
  output logic [7:0]       loadByte,
  output logic [1:0]       cpuChannel
);

  logic       cpuAccess;
  logic       cpuWrite;
  logic       cpuRead;
  logic       channelAccess;
  logic       byteFlipFlop;
  logic [7:0] commandReg;
  logic [7:0] modeReg [numChannels];
  logic [3:0] tcStatus;
  logic [3:0] statusClear;
  logic [1:0] modeChannel;
  logic [15:0] selWord;

  // the cpu is locked out while the controller owns the bus
  assign cpuAccess     = !csN && !aen;
  assign cpuWrite      = cpuAccess && !cpuWriteN;
  assign cpuRead       = cpuAccess && !cpuReadN;
  assign channelAccess = (cpuRead || cpuWrite) && !cpuAddr[3];

  assign masterClear = cpuWrite && (cpuAddr == regMasterClear);
  assign modeChannel = cpuDataIn[modeChannelLsb +: 2];

  // even address is the address register, odd is the word count
  assign cntLoadAddr  = cpuWrite && !cpuAddr[3] && !cpuAddr[0];
  assign cntLoadCount = cpuWrite && !cpuAddr[3] && cpuAddr[0];
  assign loadChannel  = cpuAddr[2:1];
  assign loadHigh     = byteFlipFlop;
  assign loadByte     = cpuDataIn;
  assign cpuChannel   = cpuAddr[2:1];

  always_ff @(posedge busIf) begin
    if (reset || masterClear) begin
      byteFlipFlop <= 1'b0;
    end else if (cpuWrite && cpuAddr == regClearFlipFlop) begin
      byteFlipFlop <= 1'b0;
    end else if (channelAccess) begin
      byteFlipFlop <= !byteFlipFlop;
    end
  end

  always_ff @(posedge busIf) begin
    if (reset || masterClear) begin
      commandReg <= 8'h00;
      for (int i = 0; i < numChannels; i++) begin
        modeReg[i] <= 8'h00;
      end
    end else begin
      if (cpuWrite && cpuAddr == regCommandStatus) begin
        commandReg <= cpuDataIn;
      end
      // the channel number travels in the mode byte itself
      if (cpuWrite && cpuAddr == regMode) begin
        modeReg[modeChannel] <= cpuDataIn;
      end
    end
  end

  assign statusClear = (cpuRead && cpuAddr == regCommandStatus) ? 4'hf : 4'h0;

  always_ff @(posedge busIf) begin
    if (reset || masterClear) begin
      tcStatus <= 4'h0;
    end else begin
      // a new terminal count wins over a clearing read in the same cycle
      tcStatus <= (tcStatus & ~statusClear) | tcPulse;
    end
  end

  assign controllerDisable = commandReg[cmdDisableBit];
  assign rotating          = commandReg[cmdRotatingBit];

  // mode fields of the channel being served
  assign xferType  = xferType_t'(modeReg[activeChannel][modeTypeLsb +: 2]);
  assign autoInit  = modeReg[activeChannel][modeAutoInitBit];
  assign decrement = modeReg[activeChannel][modeDecrementBit];

  assign selWord = cpuAddr[0] ? readCount : readAddr;

  always_comb begin
    cpuDataOut = 8'h00;
    if (!cpuAddr[3]) begin
      cpuDataOut = byteFlipFlop ? selWord[15:8] : selWord[7:0];
    end else if (cpuAddr == regCommandStatus) begin
      // upper nibble shows the request lines as they are now
      cpuDataOut = {dreq, tcStatus};
    end
  end

endmodule

`default_nettype wire

//--- verilog/dmaTimingControl.sv
`timescale 1ns/1ps
`default_nettype none

module dmaTimingControl
  import dmaPkg::*;
(
  input  wire logic       busIf,
  input  wire logic       reset,
  input  wire logic       anyRequest,
  input  wire logic [1:0] grantChannel,
  input  wire logic       hlda,
  input  wire logic       controllerDisable,
  input  xferType_t       xferType,
  input  wire logic       terminalCount,
  output dmaState_t       state,
  output logic [1:0]      activeChannel,
  output logic            hrq,
  output logic            aen,
  output logic            adstb,
  output logic [3:0]      dack,
  output logic            memrN,
  output logic            memwN,
  output logic            ioReadN,
  output logic            ioWriteN,
  output logic            eopN,
  output logic            stepPulse,
  output logic            serviceDone
);

  dmaState_t nextState;
  logic      inTransfer;
  logic      inS4;

  always_comb begin
    nextState = state;
    unique case (state)
      stateSI: if (anyRequest && !controllerDisable) nextState = stateSO;
      // hold here until the cpu gives up the bus
      stateSO: if (hlda) nextState = stateS1;
      stateS1: nextState = stateS2;
      stateS2: nextState = stateS4;
      stateS4: nextState = stateSI;
      default: nextState = stateSI;
    endcase
  end

  always_ff @(posedge busIf) begin
    if (reset) begin
      state         <= stateSI;
      activeChannel <= 2'd0;
    end else begin
      state <= nextState;
      // channel is frozen for the rest of the cycle
      if (state == stateSO && hlda) begin
        activeChannel <= grantChannel;
      end
    end
  end

  assign inTransfer = (state == stateS2) || (state == stateS4);
  assign inS4       = (state == stateS4);

  // bus stays requested until the transfer finishes
  assign hrq   = (state != stateSI);
  assign aen   = (state == stateS1) || inTransfer;
  assign adstb = (state == stateS1);
  assign dack  = inTransfer ? (4'b0001 << activeChannel) : 4'b0000;

  // write moves io to memory, read moves memory to io
  assign ioReadN  = !(inTransfer && xferType == xferWrite);
  assign memwN    = !(inS4 && xferType == xferWrite);
  assign memrN    = !(inTransfer && xferType == xferRead);
  assign ioWriteN = !(inS4 && xferType == xferRead);

  assign eopN        = !(inS4 && terminalCount);
  assign stepPulse   = inS4;
  assign serviceDone = inS4;

endmodule

`default_nettype wire
